// File: Bender.yml
package:
  name: blimp_core

sources:
  # RTL in compile order
  - files:
      - hdl/blimp_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/decode_issue_unit.sv
      - hdl/alu_unit.sv
      - hdl/mul_unit.sv
      - hdl/writeback_commit_unit.sv
      - hdl/blimp_core.sv
  # Testbench
  - target: simulation
    files:
      - verif/commit_checker.sv
      - verif/blimp_core_tb.sv

// File: blimp_core.f
hdl/blimp_pkg.sv
hdl/fetch_unit.sv
hdl/decode_issue_unit.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/writeback_commit_unit.sv
hdl/blimp_core.sv
verif/commit_checker.sv
verif/blimp_core_tb.sv

// File: hdl/alu_unit.sv
/*
 * Single-cycle adder pipe
 */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import blimp_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  d_x_msg_t alu_in,
  input  logic     alu_val,
  output x_w_msg_t alu_out,
  output logic     alu_out_val
);

  logic [xlen-1:0] sum;
  assign sum = alu_in.op_a + alu_in.op_b;

  always_ff @(posedge clk) begin
    if (rst)
      alu_out_val <= 1'b0;
    else
      alu_out_val <= alu_val;
  end

  // Result and metadata, one cycle after issue
  always_ff @(posedge clk) begin
    alu_out.seq   <= alu_in.seq;
    alu_out.pc    <= alu_in.pc;
    alu_out.waddr <= alu_in.waddr;
    alu_out.wen   <= alu_in.wen;
    alu_out.wdata <= (alu_in.uop == UOP_ADD) ? sum : '0;  // NOP yields zero
  end

endmodule

`default_nettype wire

// File: hdl/blimp_core.sv
/*
 * Core top level: fetch, decode-issue, ALU and multiplier pipes,
 * writeback-commit, with the commit stream as instruction trace
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_core import blimp_pkg::*; (
  input  logic            clk,
  input  logic            rst,

  //------------------------------------------------------------
  // Instruction memory
  //------------------------------------------------------------

  output logic            inst_req_val,
  output logic [xlen-1:0] inst_req_addr,
  input  logic [xlen-1:0] inst_resp_data,

  //------------------------------------------------------------
  // Instruction trace
  //------------------------------------------------------------

  output commit_msg_t     inst_trace
);

  f_d_msg_t    f_d_msg;
  logic        f_d_val;
  logic        f_d_rdy;
  d_x_msg_t    alu_in;
  logic        alu_val;
  d_x_msg_t    mul_in;
  logic        mul_val;
  x_w_msg_t    alu_out;
  logic        alu_out_val;
  x_w_msg_t    mul_out;
  logic        mul_out_val;
  commit_msg_t commit;
  logic        rob_free;
  logic        issue_fire;   // ROB allocation strobe

  assign inst_trace = commit;

  fetch_unit i_fetch_unit (.*);

  decode_issue_unit i_decode_issue_unit (.*);

  alu_unit i_alu_unit (.*);

  mul_unit i_mul_unit (.*);

  writeback_commit_unit i_writeback_commit_unit (.*);

endmodule

`default_nettype wire

// File: hdl/blimp_pkg.sv
/*
 * Shared widths, RV32 opcode fields, micro-op enum and the
 * message structs passed between the core's units
 */
`default_nettype none

package blimp_pkg;

  //------------------------------------------------------------
  // Sizes
  //------------------------------------------------------------

  localparam int xlen          = 32;
  localparam int seq_num_bits  = 5;
  localparam int rob_depth     = 32;  // Also the in-flight limit
  localparam int reg_addr_bits = 5;
  localparam int mul_stages    = 4;

  //------------------------------------------------------------
  // RV32 encodings
  //------------------------------------------------------------

  localparam logic [6:0] opc_op     = 7'b0110011;  // R-type ALU
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // I-type ALU
  localparam logic [2:0] f3_add     = 3'b000;      // ADD, ADDI, MUL share it
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_muldiv  = 7'b0000001;  // M extension

  // Micro-operations seen by the pipes
  typedef enum logic [1:0] {
    UOP_ADD = 2'd0,
    UOP_MUL = 2'd1,
    UOP_NOP = 2'd2
  } uop_t;

  //------------------------------------------------------------
  // Messages
  //------------------------------------------------------------

  // Fetch to decode
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } f_d_msg_t;

  // Decode to a pipe, op_b already holds the immediate for ADDI
  typedef struct packed {
    logic [seq_num_bits-1:0]  seq;
    logic [xlen-1:0]          pc;
    uop_t                     uop;
    logic [xlen-1:0]          op_a;
    logic [xlen-1:0]          op_b;
    logic [reg_addr_bits-1:0] waddr;
    logic                     wen;
  } d_x_msg_t;

  // Pipe to writeback
  typedef struct packed {
    logic [seq_num_bits-1:0]  seq;
    logic [xlen-1:0]          pc;
    logic [reg_addr_bits-1:0] waddr;
    logic [xlen-1:0]          wdata;
    logic                     wen;
  } x_w_msg_t;

  // Retirement record, also the instruction trace
  typedef struct packed {
    logic                     val;
    logic [xlen-1:0]          pc;
    logic [reg_addr_bits-1:0] waddr;
    logic [xlen-1:0]          wdata;
    logic                     wen;
  } commit_msg_t;

endpackage

`default_nettype wire

// File: hdl/decode_issue_unit.sv
/*
 * Decode and issue: RV32 field decode, register file, scoreboard,
 * sequence numbers and steering to the ALU or multiplier pipe
 */
`timescale 1ns/1ps
`default_nettype none

module decode_issue_unit import blimp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  f_d_msg_t    f_d_msg,
  input  logic        f_d_val,
  output logic        f_d_rdy,
  output d_x_msg_t    alu_in,
  output logic        alu_val,
  output d_x_msg_t    mul_in,
  output logic        mul_val,
  input  commit_msg_t commit,
  input  logic        rob_free,
  output logic        issue_fire
);

  //------------------------------------------------------------
  // Field decode
  //------------------------------------------------------------

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [reg_addr_bits-1:0] rd;
  logic [xlen-1:0]          imm_i;

  assign opcode = f_d_msg.inst[6:0];
  assign rd     = f_d_msg.inst[11:7];
  assign funct3 = f_d_msg.inst[14:12];
  assign rs1    = f_d_msg.inst[19:15];
  assign rs2    = f_d_msg.inst[24:20];
  assign funct7 = f_d_msg.inst[31:25];
  assign imm_i  = {{(xlen-12){f_d_msg.inst[31]}}, f_d_msg.inst[31:20]};  // Sign-extended

  uop_t uop;
  logic is_imm;    // ADDI takes op_b from the immediate
  logic uses_rs1;
  logic uses_rs2;

  always_comb begin
    uop      = UOP_NOP;  // Anything unknown still commits
    is_imm   = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    if (opcode == opc_op && funct3 == f3_add && funct7 == f7_base) begin
      uop      = UOP_ADD;
      uses_rs1 = 1'b1;
      uses_rs2 = 1'b1;
    end else if (opcode == opc_op && funct3 == f3_add && funct7 == f7_muldiv) begin
      uop      = UOP_MUL;
      uses_rs1 = 1'b1;
      uses_rs2 = 1'b1;
    end else if (opcode == opc_op_imm && funct3 == f3_add) begin
      uop      = UOP_ADD;
      is_imm   = 1'b1;
      uses_rs1 = 1'b1;
    end
  end

  logic wen;
  assign wen = (uop != UOP_NOP) && (rd != '0);  // x0 never written

  //------------------------------------------------------------
  // Register file and scoreboard
  //------------------------------------------------------------

  logic [xlen-1:0]           regs [32];
  logic [31:0]               pending_q;  // One bit per architectural reg
  logic [seq_num_bits-1:0]   seq_q;
  logic [xlen-1:0]           rs1_data;
  logic [xlen-1:0]           rs2_data;

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  logic stall;
  assign stall = (uses_rs1 && pending_q[rs1]) ||
                 (uses_rs2 && pending_q[rs2]) ||
                 (wen && pending_q[rd])       ||  // Keep one writer per reg
                 !rob_free;

  assign f_d_rdy    = !stall;
  assign issue_fire = f_d_val && f_d_rdy;

  //------------------------------------------------------------
  // Issue
  //------------------------------------------------------------

  d_x_msg_t issue_msg;
  assign issue_msg = '{
    seq:   seq_q,
    pc:    f_d_msg.pc,
    uop:   uop,
    op_a:  rs1_data,
    op_b:  is_imm ? imm_i : rs2_data,
    waddr: rd,
    wen:   wen
  };

  assign alu_in  = issue_msg;
  assign mul_in  = issue_msg;
  assign alu_val = issue_fire && (uop != UOP_MUL);  // NOPs ride the ALU
  assign mul_val = issue_fire && (uop == UOP_MUL);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
      seq_q     <= '0;
      regs      <= '{default: '0};  // Architectural state starts at zero
    end else begin
      if (commit.val && commit.wen) begin
        regs[commit.waddr]      <= commit.wdata;
        pending_q[commit.waddr] <= 1'b0;
      end
      if (issue_fire) begin
        seq_q <= seq_q + 1'b1;      // Wraps modulo rob_depth
        if (wen)
          pending_q[rd] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
/*
 * PC register, instruction memory request and one-entry fetch buffer
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import blimp_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  output logic            inst_req_val,
  output logic [xlen-1:0] inst_req_addr,
  input  logic [xlen-1:0] inst_resp_data,
  output f_d_msg_t        f_d_msg,
  output logic            f_d_val,
  input  logic            f_d_rdy
);

  logic            run_q;      // Rises one cycle after reset
  logic [xlen-1:0] pc_q;
  logic            resp_val_q; // Response arrives this cycle
  logic [xlen-1:0] resp_pc_q;  // PC of the outstanding request
  logic            buf_val_q;
  f_d_msg_t        buf_msg_q;  // Word held while decode stalls

  // Held word and live response never overlap
  assign f_d_val = resp_val_q | buf_val_q;
  assign f_d_msg = buf_val_q ? buf_msg_q
                             : f_d_msg_t'{pc: resp_pc_q, inst: inst_resp_data};

  // Request only when nothing will be left over in the buffer
  assign inst_req_val  = run_q && (!f_d_val || f_d_rdy);
  assign inst_req_addr = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q      <= 1'b0;
      pc_q       <= '0;
      resp_val_q <= 1'b0;
      buf_val_q  <= 1'b0;
    end else begin
      run_q      <= 1'b1;
      resp_val_q <= inst_req_val;
      if (inst_req_val) begin
        pc_q      <= pc_q + xlen'(4);
        resp_pc_q <= pc_q;             // Travels with the returned word
      end
      if (resp_val_q && !f_d_rdy) begin
        buf_val_q <= 1'b1;             // Park the word while decode stalls
        buf_msg_q <= f_d_msg;
      end else if (buf_val_q && f_d_rdy) begin
        buf_val_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/mul_unit.sv
/*
 * Pipelined 32-bit multiplier, low half of the product,
 * one operand slice accumulated per stage
 */
`timescale 1ns/1ps
`default_nettype none

module mul_unit import blimp_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  d_x_msg_t mul_in,
  input  logic     mul_val,
  output x_w_msg_t mul_out,
  output logic     mul_out_val
);

  localparam int slice = xlen / mul_stages;  // Bits of op_b per stage

  logic [mul_stages-1:0] val_q;
  d_x_msg_t              msg_q [mul_stages];  // Operands and metadata
  logic [xlen-1:0]       acc_q [mul_stages];  // Running partial sum

  // Partial product for one slice of b, shifted into place
  function automatic logic [xlen-1:0] partial_prod(input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b,
                                                   input int idx);
    logic [slice-1:0] b_slice;
    b_slice      = b[idx*slice +: slice];
    partial_prod = (a * {{(xlen-slice){1'b0}}, b_slice}) << (idx * slice);
  endfunction

  always_ff @(posedge clk) begin
    if (rst)
      val_q <= '0;
    else
      val_q <= {val_q[mul_stages-2:0], mul_val};  // Valid shifts with data
  end

  always_ff @(posedge clk) begin
    msg_q[0] <= mul_in;
    acc_q[0] <= partial_prod(mul_in.op_a, mul_in.op_b, 0);
    for (int i = 1; i < mul_stages; i++) begin
      msg_q[i] <= msg_q[i-1];
      acc_q[i] <= acc_q[i-1] + partial_prod(msg_q[i-1].op_a, msg_q[i-1].op_b, i);
    end
  end

  // Last stage holds the full low product
  assign mul_out_val   = val_q[mul_stages-1];
  assign mul_out.seq   = msg_q[mul_stages-1].seq;
  assign mul_out.pc    = msg_q[mul_stages-1].pc;
  assign mul_out.waddr = msg_q[mul_stages-1].waddr;
  assign mul_out.wen   = msg_q[mul_stages-1].wen;
  assign mul_out.wdata = acc_q[mul_stages-1];

endmodule

`default_nettype wire

// File: hdl/writeback_commit_unit.sv
/*
 * Writeback and commit: reorder buffer indexed by sequence number,
 * out-of-order result capture, in-order retirement
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_commit_unit import blimp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  x_w_msg_t    alu_out,
  input  logic        alu_out_val,
  input  x_w_msg_t    mul_out,
  input  logic        mul_out_val,
  input  logic        issue_fire,
  output commit_msg_t commit,
  output logic        rob_free
);

  localparam int count_bits = $clog2(rob_depth + 1);

  //------------------------------------------------------------
  // Reorder buffer state
  //------------------------------------------------------------

  x_w_msg_t                rob_msg [rob_depth];   // Captured results
  logic [rob_depth-1:0]    rob_done_q;            // Result present
  logic [seq_num_bits-1:0] head_q;                // Oldest in flight
  logic [count_bits-1:0]   count_q;               // Entries allocated

  logic commit_fire;
  assign commit_fire = rob_done_q[head_q];

  assign rob_free = (count_q < count_bits'(rob_depth));

  //------------------------------------------------------------
  // Retirement
  //------------------------------------------------------------

  assign commit.val   = commit_fire;
  assign commit.pc    = rob_msg[head_q].pc;
  assign commit.waddr = rob_msg[head_q].waddr;
  assign commit.wdata = rob_msg[head_q].wdata;
  assign commit.wen   = rob_msg[head_q].wen;

  // Payload capture, both pipes may land in one cycle
  always_ff @(posedge clk) begin
    if (alu_out_val)
      rob_msg[alu_out.seq] <= alu_out;
    if (mul_out_val)
      rob_msg[mul_out.seq] <= mul_out;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rob_done_q <= '0;
      head_q     <= '0;
      count_q    <= '0;
    end else begin
      if (commit_fire) begin
        rob_done_q[head_q] <= 1'b0;   // Free the slot
        head_q             <= head_q + 1'b1;
      end
      if (alu_out_val)
        rob_done_q[alu_out.seq] <= 1'b1;
      if (mul_out_val)
        rob_done_q[mul_out.seq] <= 1'b1;

      // Allocate on issue, release on commit
      case ({issue_fire, commit_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verif/blimp_core_tb.sv
/*
 * Testbench top: clock and reset, LFSR program generator,
 * instruction memory model and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_core_tb import blimp_pkg::*; ();

  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int num_insts    = 200;
  localparam int mem_words    = 256;
  localparam int watchdog_ns  = (num_insts * 12 + reset_cycles) * clk_period;
  localparam logic [31:0] nop_word = 32'h0000_0013;  // ADDI x0, x0, 0

  logic            clk;
  logic            rst;
  logic            inst_req_val;
  logic [xlen-1:0] inst_req_addr;
  logic [xlen-1:0] inst_resp_data;
  commit_msg_t     inst_trace;
  logic [31:0]     prog [mem_words];   // Program image, shared with checker
  logic [31:0]     lfsr_q;
  logic            done;
  int              tests_failed;

  blimp_core i_blimp_core (
    .clk            (clk),
    .rst            (rst),
    .inst_req_val   (inst_req_val),
    .inst_req_addr  (inst_req_addr),
    .inst_resp_data (inst_resp_data),
    .inst_trace     (inst_trace)
  );

  commit_checker #(.num_insts(num_insts)) i_commit_checker (
    .clk           (clk),
    .rst           (rst),
    .inst_req_val  (inst_req_val),
    .inst_req_addr (inst_req_addr),
    .inst_trace    (inst_trace),
    .prog          (prog),
    .done          (done),
    .tests_failed  (tests_failed)
  );

  //------------------------------------------------------------
  // Program generation
  //------------------------------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);          // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic build_program();
    logic [31:0] op;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    for (int i = 0; i < mem_words; i++) begin
      if (i >= num_insts) begin
        prog[i] = nop_word;                // Tail of no-ops
      end else begin
        take_bits(2, op);
        take_bits(3, rd);                  // x0 to x7 only
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(12, imm);
        case (op[1:0])
          2'd0:    prog[i] = {7'h00, 2'b00, rs2[2:0], 2'b00, rs1[2:0], 3'b000,
                              2'b00, rd[2:0], 7'b0110011};   // ADD
          2'd1:    prog[i] = {7'h01, 2'b00, rs2[2:0], 2'b00, rs1[2:0], 3'b000,
                              2'b00, rd[2:0], 7'b0110011};   // MUL
          default: prog[i] = {imm[11:0], 2'b00, rs1[2:0], 3'b000,
                              2'b00, rd[2:0], 7'b0010011};   // ADDI
        endcase
      end
    end
  endtask

  //------------------------------------------------------------
  // Clock, memory model, sequencing
  //------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Answers one cycle after each request
  always @(posedge clk) begin
    if (inst_req_val)
      inst_resp_data <= (inst_req_addr < 4 * mem_words) ? prog[inst_req_addr[9:2]] : nop_word;
  end

  initial begin
    rst            = 1'b1;
    inst_resp_data = '0;
    lfsr_q         = 32'hb78b2c7e;
    build_program();
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    if (tests_failed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Watchdog, bounded by the program length
  initial begin
    #(watchdog_ns);
    $display("Timeout: the commit stream stalled before all %0d instructions retired",
             num_insts);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/commit_checker.sv
/*
 * Commit checker: ISA model of the program, per-commit comparison
 * of the instruction trace and the closing per-test report
 */
`timescale 1ns/1ps
`default_nettype none

module commit_checker import blimp_pkg::*; #(
  parameter int num_insts = 200
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inst_req_val,
  input  logic [xlen-1:0] inst_req_addr,
  input  commit_msg_t     inst_trace,
  input  logic [31:0]     prog [256],
  output logic            done,
  output int              tests_failed
);

  localparam int num_tests = 5;

  logic [31:0] model_regs [32];  // Architectural state of the model
  logic [31:0] last_seen [32];   // Last value the DUT committed per reg
  logic [31:0] model_pc;
  int          commits;
  int          errs [num_tests];
  logic        req_seen;         // First fetch request observed

  initial begin
    model_regs   = '{default: '0};
    last_seen    = '{default: '0};
    model_pc     = '0;
    commits      = 0;
    errs         = '{default: 0};
    req_seen     = 1'b0;
    done         = 1'b0;
    tests_failed = 0;
  end

  function automatic string test_name(input int t);
    case (t)
      0:       return "reset_and_first_fetch";
      1:       return "program_order";
      2:       return "result_values";
      3:       return "x0_handling";
      default: return "completion_and_final_regs";
    endcase
  endfunction

  task automatic report(input int t);
    $display("test %0d %s: %s (%0d errors)", t + 1, test_name(t),
             (errs[t] == 0) ? "PASS" : "FAIL", errs[t]);
  endtask

  //------------------------------------------------------------
  // One retirement against the ISA model
  //------------------------------------------------------------

  task automatic check_commit();
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic        known;
    logic        exp_wen;
    logic        reads_x0;
    inst     = prog[model_pc[9:2]];
    rd       = inst[11:7];
    a        = model_regs[inst[19:15]];
    b        = model_regs[inst[24:20]];
    known    = 1'b1;
    exp      = '0;
    reads_x0 = (inst[19:15] == 0) || (inst[6:0] == 7'h33 && inst[24:20] == 0);
    if (inst[6:0] == 7'h33 && inst[14:12] == 0 && inst[31:25] == 7'h00)
      exp = a + b;                                   // ADD
    else if (inst[6:0] == 7'h33 && inst[14:12] == 0 && inst[31:25] == 7'h01)
      exp = a * b;                                   // MUL, low 32 bits
    else if (inst[6:0] == 7'h13 && inst[14:12] == 0)
      exp = a + {{20{inst[31]}}, inst[31:20]};       // ADDI
    else
      known = 1'b0;
    exp_wen = known && (rd != 0);

    if (inst_trace.pc !== model_pc) begin
      errs[1]++;
      $display("ERROR %0t: commit pc %h, expected %h", $time, inst_trace.pc, model_pc);
    end
    if (inst_trace.wen !== exp_wen) begin
      if (known && rd == 0)
        errs[3]++;                                   // x0 write leaked
      else
        errs[2]++;
      $display("ERROR %0t: pc %h wen %b, expected %b", $time, model_pc,
               inst_trace.wen, exp_wen);
    end else if (exp_wen && (inst_trace.waddr !== rd || inst_trace.wdata !== exp)) begin
      errs[2]++;
      if (reads_x0)
        errs[3]++;                                   // Likely a bad x0 read
      $display("ERROR %0t: pc %h wrote x%0d=%h, expected x%0d=%h", $time, model_pc,
               inst_trace.waddr, inst_trace.wdata, rd, exp);
    end

    if (exp_wen)
      model_regs[rd] = exp;
    if (inst_trace.wen)
      last_seen[inst_trace.waddr] = inst_trace.wdata;
    model_pc = model_pc + 4;
    commits++;
  endtask

  // Final register compare, remaining test lines and counts
  task automatic finish_tests();
    int passed;
    passed = 0;
    for (int r = 1; r < 32; r++) begin
      if (model_regs[r] !== last_seen[r]) begin
        errs[4]++;
        $display("ERROR %0t: final x%0d is %h, model has %h", $time, r,
                 last_seen[r], model_regs[r]);
      end
    end
    for (int t = 1; t < num_tests; t++)
      report(t);
    for (int t = 0; t < num_tests; t++)
      if (errs[t] == 0)
        passed++;
    tests_failed = num_tests - passed;
    $display("passed %0d failed %0d", passed, tests_failed);
    done = 1'b1;
  endtask

  always @(posedge clk) begin
    if (!rst && !done) begin
      if (inst_req_val && !req_seen) begin
        req_seen <= 1'b1;
        if (inst_req_addr !== '0) begin
          errs[0]++;
          $display("ERROR %0t: first fetch at %h, expected 0", $time, inst_req_addr);
        end
      end
      if (inst_trace.val && !req_seen) begin
        errs[0]++;                                   // Nothing fetched yet
        $display("ERROR %0t: commit before first instruction response", $time);
      end
      if (inst_trace.val) begin
        check_commit();
        if (commits == 1)
          report(0);
        if (commits == num_insts)
          finish_tests();
      end
    end
  end

endmodule

`default_nettype wire
